// ==== verilog/channel_buffer_pkg.sv ====
package channel_buffer_pkg;

    // feature map geometry
    localparam int IMAGE_WIDTH  = 26;
    localparam int IMAGE_HEIGHT = 34;
    localparam int CHANNELS     = 32;
    localparam int DATA_BITS    = 32;

    localparam int ROW_BITS = 6;
    localparam int COL_BITS = 5;

    // 2x2 windows, stride 2
    localparam int WINDOW_ROWS  = IMAGE_HEIGHT / 2;
    localparam int WINDOW_COLS  = IMAGE_WIDTH / 2;
    localparam int WINDOW_COUNT = WINDOW_ROWS * WINDOW_COLS;
    localparam int WIN_IDX_BITS = 11;

    typedef logic [DATA_BITS-1:0] sample_t;

    // channel 0 sits in the lowest slice
    typedef sample_t [CHANNELS-1:0] pixel_t;

    typedef struct packed {
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
    } pixel_pos_t;

    typedef struct packed {
        logic       en;
        pixel_pos_t pos;
        pixel_t     pixel;
    } store_wr_t;

    typedef struct packed {
        pixel_t                  top_left;
        pixel_t                  top_right;
        pixel_t                  bottom_left;
        pixel_t                  bottom_right;
        logic [WIN_IDX_BITS-1:0] index;
    } window_t;

    typedef enum logic {
        FILL  = 1'b0,
        DRAIN = 1'b1
    } buf_state_e;

endpackage

// ==== verilog/buffer_sequencer.sv ====
`timescale 1ns/1ps

module buffer_sequencer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           fill_last,
    input  logic                           drain_last,
    output channel_buffer_pkg::buf_state_e state,
    output logic                           frame_done
);

    // two-state fill/drain control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= channel_buffer_pkg::FILL;
        end else begin
            unique case (state)
                channel_buffer_pkg::FILL: begin
                    if (fill_last) begin
                        state <= channel_buffer_pkg::DRAIN;
                    end
                end
                channel_buffer_pkg::DRAIN: begin
                    if (drain_last) begin
                        state <= channel_buffer_pkg::FILL;
                    end
                end
                default: begin
                    state <= channel_buffer_pkg::FILL;
                end
            endcase
        end
    end

    // drain_last marks the address cycle of the final window, so
    // the registered flag rises together with that window on the output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_done <= 1'b0;
        end else if (drain_last) begin
            frame_done <= 1'b1;
        end
    end

endmodule

// ==== verilog/raster_writer.sv ====
`timescale 1ns/1ps

module raster_writer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  channel_buffer_pkg::buf_state_e state,
    input  logic                           valid_in,
    input  channel_buffer_pkg::pixel_t     data_in,
    output channel_buffer_pkg::store_wr_t  wr,
    output logic                           fill_last
);

    logic [channel_buffer_pkg::ROW_BITS-1:0] row;
    logic [channel_buffer_pkg::COL_BITS-1:0] col;
    logic                                    accept;
    logic                                    last_col;
    logic                                    last_row;

    // state is still FILL while fill_last is up, so hold off the next
    // frame until the sequencer has switched over
    assign accept = valid_in && (state == channel_buffer_pkg::FILL) && !fill_last;

    assign last_col = (col == channel_buffer_pkg::IMAGE_WIDTH - 1);
    assign last_row = (row == channel_buffer_pkg::IMAGE_HEIGHT - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row       <= '0;
            col       <= '0;
            fill_last <= 1'b0;
        end else begin
            fill_last <= 1'b0;
            if (accept) begin
                if (last_col) begin
                    col <= '0;
                    if (last_row) begin
                        row       <= '0;
                        fill_last <= 1'b1;
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // write lands in the store on the accepting edge
    always_comb begin
        wr.en      = accept;
        wr.pos.row = row;
        wr.pos.col = col;
        wr.pixel   = data_in;
    end

endmodule

// ==== verilog/frame_store.sv ====
`timescale 1ns/1ps

module frame_store (
    input  logic                           clk,
    input  channel_buffer_pkg::store_wr_t  wr,
    input  logic                           rd_en,
    input  channel_buffer_pkg::pixel_pos_t rd_pos,
    output channel_buffer_pkg::window_t    quad
);

    channel_buffer_pkg::pixel_t mem [channel_buffer_pkg::IMAGE_HEIGHT]
                                    [channel_buffer_pkg::IMAGE_WIDTH];

    logic [channel_buffer_pkg::ROW_BITS-1:0] row_top;
    logic [channel_buffer_pkg::ROW_BITS-1:0] row_bot;
    logic [channel_buffer_pkg::COL_BITS-1:0] col_left;
    logic [channel_buffer_pkg::COL_BITS-1:0] col_right;

    // top-left is always even, so the neighbour is just bit 0 set
    assign row_top   = rd_pos.row;
    assign row_bot   = {rd_pos.row[channel_buffer_pkg::ROW_BITS-1:1], 1'b1};
    assign col_left  = rd_pos.col;
    assign col_right = {rd_pos.col[channel_buffer_pkg::COL_BITS-1:1], 1'b1};

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.pos.row][wr.pos.col] <= wr.pixel;
        end
    end

    // one-cycle read of the whole 2x2 quad, all channels at once
    always_ff @(posedge clk) begin
        if (rd_en) begin
            quad <= '{
                top_left:     mem[row_top][col_left],
                top_right:    mem[row_top][col_right],
                bottom_left:  mem[row_bot][col_left],
                bottom_right: mem[row_bot][col_right],
                index:        '0
            };
        end
    end

endmodule

// ==== verilog/window_reader.sv ====
`timescale 1ns/1ps

module window_reader (
    input  logic                           clk,
    input  logic                           rst_n,
    input  channel_buffer_pkg::buf_state_e state,
    input  channel_buffer_pkg::window_t    quad,
    output logic                           rd_en,
    output channel_buffer_pkg::pixel_pos_t rd_pos,
    output logic                           drain_last,
    output logic                           valid_out,
    output channel_buffer_pkg::window_t    window_out
);

    logic [channel_buffer_pkg::ROW_BITS-1:0]     win_row;
    logic [channel_buffer_pkg::COL_BITS-1:0]     win_col;
    logic [channel_buffer_pkg::WIN_IDX_BITS-1:0] addr_idx;
    logic [channel_buffer_pkg::WIN_IDX_BITS-1:0] out_idx;
    logic                                        row_end;
    logic                                        last_row;

    // one window address per drain cycle
    assign rd_en = (state == channel_buffer_pkg::DRAIN);

    assign rd_pos.row = win_row;
    assign rd_pos.col = win_col;

    assign row_end  = (win_col == channel_buffer_pkg::IMAGE_WIDTH - 2);
    assign last_row = (win_row == channel_buffer_pkg::IMAGE_HEIGHT - 2);

    assign drain_last = rd_en && (addr_idx == channel_buffer_pkg::WINDOW_COUNT - 1);

    // stride-2 walk over window top-left corners
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_row <= '0;
            win_col <= '0;
        end else if (rd_en) begin
            if (row_end) begin
                win_col <= '0;
                if (last_row) begin
                    win_row <= '0;
                end else begin
                    win_row <= win_row + channel_buffer_pkg::ROW_BITS'(2);
                end
            end else begin
                win_col <= win_col + channel_buffer_pkg::COL_BITS'(2);
            end
        end
    end

    // index of the window being addressed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_idx <= '0;
        end else if (rd_en) begin
            if (drain_last) begin
                addr_idx <= '0;
            end else begin
                addr_idx <= addr_idx + 1'b1;
            end
        end
    end

    // follow the store's read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            out_idx   <= '0;
        end else begin
            valid_out <= rd_en;
            if (rd_en) begin
                out_idx <= addr_idx;
            end
        end
    end

    always_comb begin
        window_out       = quad;
        window_out.index = out_idx;
    end

endmodule

// ==== verilog/channel_buffer.sv ====
`timescale 1ns/1ps

module channel_buffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        valid_in,
    input  channel_buffer_pkg::pixel_t  data_in,
    output logic                        valid_out,
    output channel_buffer_pkg::window_t window_out,
    output logic                        frame_done
);

    channel_buffer_pkg::buf_state_e state;
    channel_buffer_pkg::store_wr_t  wr;
    channel_buffer_pkg::pixel_pos_t rd_pos;
    channel_buffer_pkg::window_t    quad;
    logic                           fill_last;
    logic                           drain_last;
    logic                           rd_en;

    buffer_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_last  (fill_last),
        .drain_last (drain_last),
        .state      (state),
        .frame_done (frame_done)
    );

    // capture side
    raster_writer u_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .state     (state),
        .valid_in  (valid_in),
        .data_in   (data_in),
        .wr        (wr),
        .fill_last (fill_last)
    );

    frame_store u_store (
        .clk    (clk),
        .wr     (wr),
        .rd_en  (rd_en),
        .rd_pos (rd_pos),
        .quad   (quad)
    );

    // drain side
    window_reader u_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .quad       (quad),
        .rd_en      (rd_en),
        .rd_pos     (rd_pos),
        .drain_last (drain_last),
        .valid_out  (valid_out),
        .window_out (window_out)
    );

endmodule

// ==== bench/channel_buffer_properties.sv ====
`timescale 1ns/1ps

module channel_buffer_properties (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        valid_out,
    input channel_buffer_pkg::window_t window_out,
    input logic                        frame_done
);

    logic [channel_buffer_pkg::WIN_IDX_BITS-1:0] next_index;
    int                                          fail_count;

    // index expected on the next valid window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_index <= '0;
        end else if (valid_out) begin
            if (window_out.index == channel_buffer_pkg::WINDOW_COUNT - 1) begin
                next_index <= '0;
            end else begin
                next_index <= window_out.index + 1'b1;
            end
        end
    end

    index_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_out |-> window_out.index == next_index
    ) else begin
        fail_count++;
        $error("window index out of order");
    end

    done_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_done |=> frame_done
    ) else begin
        fail_count++;
        $error("frame_done fell after being set");
    end

    valid_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_out [*channel_buffer_pkg::WINDOW_COUNT] |=> !valid_out
    ) else begin
        fail_count++;
        $error("valid_out held longer than one frame of windows");
    end

endmodule

bind channel_buffer channel_buffer_properties props0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_out  (valid_out),
    .window_out (window_out),
    .frame_done (frame_done)
);

// ==== bench/tb_channel_buffer.sv ====
`timescale 1ns/1ps

module tb_channel_buffer;

    localparam int FRAMES       = 3;
    localparam int CLK_PERIOD   = 8;
    localparam int WIDTH        = channel_buffer_pkg::IMAGE_WIDTH;
    localparam int FRAME_PIXELS = channel_buffer_pkg::IMAGE_HEIGHT * WIDTH;
    localparam int WCOLS        = channel_buffer_pkg::WINDOW_COLS;
    localparam int WCOUNT       = channel_buffer_pkg::WINDOW_COUNT;
    // three frames at 70% input density plus drain, doubled
    localparam real WATCHDOG_NS = FRAMES * (FRAME_PIXELS / 0.7 + 223.0) * CLK_PERIOD * 2.0;

    logic                        clk;
    logic                        rst_n;
    logic                        valid_in;
    channel_buffer_pkg::pixel_t  data_in;
    logic                        valid_out;
    channel_buffer_pkg::window_t window_out;
    logic                        frame_done;

    // reference model
    channel_buffer_pkg::pixel_t     model_mem [channel_buffer_pkg::IMAGE_HEIGHT][WIDTH];
    channel_buffer_pkg::buf_state_e m_state;
    logic                           fill_pending;
    int                             pix_count;
    int                             win_addr;
    logic                           exp_valid;
    logic                           exp_done;
    channel_buffer_pkg::window_t    exp_window;

    int   edge_count;
    int   accept_edge;
    int   run_length;
    int   runs_closed;
    int   ignored_count;
    logic prev_valid;

    channel_buffer dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .data_in    (data_in),
        .valid_out  (valid_out),
        .window_out (window_out),
        .frame_done (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %s: expected %0h, actual %0h", test_name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_problem(input string what);
        $display("[ERROR] %s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic drive_inputs();
        channel_buffer_pkg::pixel_t pix;
        for (int ch = 0; ch < channel_buffer_pkg::CHANNELS; ch++) begin
            pix[ch] = $urandom;
        end
        valid_in <= ($urandom % 100) < 70;
        data_in  <= pix;
    endtask

    task automatic check_quad(input string quad_name, input channel_buffer_pkg::pixel_t expected,
                              input channel_buffer_pkg::pixel_t actual);
        for (int ch = 0; ch < channel_buffer_pkg::CHANNELS; ch++) begin
            assert (actual[ch] === expected[ch])
            else report_mismatch($sformatf("window %0d %s ch %0d", exp_window.index,
                                           quad_name, ch), expected[ch], actual[ch]);
        end
    endtask

    task automatic check_outputs();
        assert (valid_out === exp_valid)
        else report_mismatch("valid_out", exp_valid, valid_out);
        assert (frame_done === exp_done)
        else report_mismatch("frame_done", exp_done, frame_done);
        if (valid_out) begin
            if (!prev_valid) begin
                assert (edge_count - accept_edge == 2)
                else report_mismatch("first_valid_delay", 2, edge_count - accept_edge);
            end
            assert (window_out.index === exp_window.index)
            else report_mismatch("window_index", exp_window.index, window_out.index);
            check_quad("top_left", exp_window.top_left, window_out.top_left);
            check_quad("top_right", exp_window.top_right, window_out.top_right);
            check_quad("bottom_left", exp_window.bottom_left, window_out.bottom_left);
            check_quad("bottom_right", exp_window.bottom_right, window_out.bottom_right);
            run_length++;
        end else if (prev_valid) begin
            assert (run_length == WCOUNT)
            else report_mismatch("valid_run_length", WCOUNT, run_length);
            run_length = 0;
            runs_closed++;
        end
        prev_valid = valid_out;
    endtask

    // predicts the outputs of the next cycle from the inputs seen at the next edge
    task automatic step_model();
        int r;
        int c;
        if (m_state == channel_buffer_pkg::DRAIN) begin
            if (valid_in) begin
                ignored_count++;
            end
            r = 2 * (win_addr / WCOLS);
            c = 2 * (win_addr % WCOLS);
            exp_window.top_left     = model_mem[r][c];
            exp_window.top_right    = model_mem[r][c+1];
            exp_window.bottom_left  = model_mem[r+1][c];
            exp_window.bottom_right = model_mem[r+1][c+1];
            exp_window.index        = win_addr;
            exp_valid = 1'b1;
            if (win_addr == WCOUNT - 1) begin
                win_addr = 0;
                m_state  = channel_buffer_pkg::FILL;
                exp_done = 1'b1;
            end else begin
                win_addr++;
            end
        end else begin
            exp_valid = 1'b0;
            if (fill_pending) begin
                // turnaround cycle, nothing is taken
                if (valid_in) begin
                    ignored_count++;
                end
                fill_pending = 1'b0;
                m_state      = channel_buffer_pkg::DRAIN;
            end else if (valid_in) begin
                model_mem[pix_count / WIDTH][pix_count % WIDTH] = data_in;
                pix_count++;
                if (pix_count == FRAME_PIXELS) begin
                    pix_count    = 0;
                    fill_pending = 1'b1;
                    accept_edge  = edge_count + 1;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(51));
        rst_n    = 1'b0;
        valid_in = 1'b0;
        data_in  = '0;

        m_state       = channel_buffer_pkg::FILL;
        fill_pending  = 1'b0;
        pix_count     = 0;
        win_addr      = 0;
        exp_valid     = 1'b0;
        exp_done      = 1'b0;
        exp_window    = '0;
        edge_count    = 0;
        accept_edge   = 0;
        run_length    = 0;
        runs_closed   = 0;
        ignored_count = 0;
        prev_valid    = 1'b0;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        drive_inputs();

        // outputs checked on the falling edge, inputs changed on the rising edge
        while (runs_closed < FRAMES) begin
            @(negedge clk);
            check_outputs();
            step_model();
            @(posedge clk);
            edge_count++;
            drive_inputs();
        end

        assert (ignored_count > 0)
        else report_problem("no pixel was offered while the buffer was draining");

        $display("Simulation passed");
        $finish;
    end

    // bound concurrent properties flag their failures here
    initial begin
        wait (dut0.props0.fail_count != 0);
        $display("[ERROR] a concurrent property on the DUT outputs failed");
        $display("Simulation failed");
        $fatal(1, "property failure");
    end

    initial begin
        #(WATCHDOG_NS);
        $display("[ERROR] watchdog expired before %0d frames were drained", FRAMES);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

// ==== tb.f ====
verilog/channel_buffer_pkg.sv
verilog/buffer_sequencer.sv
verilog/raster_writer.sv
verilog/frame_store.sv
verilog/window_reader.sv
verilog/channel_buffer.sv
bench/channel_buffer_properties.sv
bench/tb_channel_buffer.sv
